//--- include/frontend_params.svh
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// data and address width.
`define XLEN 32

// first fetch address after reset.
`define RESET_PC 32'h0000_0100

// counter table and target buffer size.
`define BHT_ENTRIES 16

// index taken from pc bits 5:2.
`define BHT_IDX_W 4

// entries held toward the decoder.
`define IBUF_DEPTH 4

// read and write pointer width of the buffer.
`define IBUF_PTR_W 2

`endif

//--- verilog/fetch_pkg.sv
`include "frontend_params.svh"

package fetch_pkg;

    // fetch control states.
    typedef enum logic [1:0] {
        FS_IDLE    = 2'd0,
        FS_REQ     = 2'd1,
        FS_DISCARD = 2'd2,
        FS_HOLD    = 2'd3
    } fetch_state_e;

    // one fetched instruction with its pc and prediction.
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
        logic             pred_taken;
        logic [`XLEN-1:0] pred_target;
    } ibuf_entry_t;

endpackage

//--- verilog/predict_pkg.sv
`include "frontend_params.svh"

package predict_pkg;

    // opcode classes, encoded with the opcode field itself.
    typedef enum logic [6:0] {
        OPC_OTHER  = 7'b0000000,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } op_class_e;

    // two-bit saturating counter.
    typedef logic [1:0] ctr2_t;

    localparam ctr2_t CTR_STRONG_NT = 2'd0;
    localparam ctr2_t CTR_WEAK_NT   = 2'd1;
    localparam ctr2_t CTR_WEAK_T    = 2'd2;
    localparam ctr2_t CTR_STRONG_T  = 2'd3;

    localparam int BTB_TAG_W = `XLEN - `BHT_IDX_W - 2;

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]     target;
    } btb_entry_t;

    function automatic logic [`BHT_IDX_W-1:0] bht_index(input logic [`XLEN-1:0] pc);
        return pc[`BHT_IDX_W+1:2];
    endfunction

    function automatic logic [BTB_TAG_W-1:0] btb_tag(input logic [`XLEN-1:0] pc);
        return pc[`XLEN-1:`BHT_IDX_W+2];
    endfunction

endpackage

//--- verilog/fetch_ctrl.sv
`timescale 1ns/100ps

`include "frontend_params.svh"

module fetch_ctrl (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`XLEN-1:0]      fetch_pc,
    output logic                  advance,
    input  logic                  redirect_valid,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic [`XLEN-1:0]      wb_adr,
    input  logic [`XLEN-1:0]      wb_dat_i,
    input  logic                  wb_ack,
    input  logic                  pred_taken,
    input  logic [`XLEN-1:0]      pred_target,
    output logic [`XLEN-1:0]      fetch_inst,
    output logic                  push,
    output fetch_pkg::ibuf_entry_t push_entry,
    input  logic                  ibuf_space
);
    import fetch_pkg::*;

    fetch_state_e     state;
    fetch_state_e     state_nxt;
    logic [`XLEN-1:0] beat_pc;
    logic             beat_done;

    assign beat_done = (state == FS_REQ) && wb_ack;

    // a redirect in the ack cycle drops the word.
    assign push    = beat_done && !redirect_valid;
    assign advance = push;

    always_comb begin
        state_nxt = state;
        case (state)
            FS_IDLE, FS_HOLD: begin
                // the buffer is flushed on redirect, so room is certain.
                if (redirect_valid || ibuf_space) begin
                    state_nxt = FS_REQ;
                end else begin
                    state_nxt = FS_HOLD;
                end
            end
            FS_REQ: begin
                if (wb_ack) begin
                    state_nxt = FS_IDLE;
                end else if (redirect_valid) begin
                    state_nxt = FS_DISCARD;
                end
            end
            FS_DISCARD: begin
                if (wb_ack) begin
                    state_nxt = FS_IDLE;
                end
            end
            default: state_nxt = FS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // fetch_pc moves on redirect, so the overtaken beat keeps its own address.
    always_ff @(posedge clk) begin
        if (state == FS_REQ) begin
            beat_pc <= fetch_pc;
        end
    end

    assign wb_cyc     = (state == FS_REQ) || (state == FS_DISCARD);
    assign wb_stb     = wb_cyc;
    assign wb_adr     = (state == FS_DISCARD) ? beat_pc : fetch_pc;
    assign fetch_inst = wb_dat_i;

    assign push_entry = '{pc:          fetch_pc,
                          inst:        wb_dat_i,
                          pred_taken:  pred_taken,
                          pred_target: pred_target};

    a_adr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb && !wb_ack |=> $stable(wb_adr));

endmodule

//--- verilog/pc_gen.sv
`timescale 1ns/100ps

`include "frontend_params.svh"

module pc_gen (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             advance,
    input  logic             pred_taken,
    input  logic [`XLEN-1:0] pred_target,
    input  logic             redirect_valid,
    input  logic [`XLEN-1:0] redirect_pc,
    output logic [`XLEN-1:0] fetch_pc
);

    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] seq_pc;

    assign seq_pc = fetch_pc + (`XLEN)'(4);

    // redirect wins over the predicted path.
    always_comb begin
        next_pc = fetch_pc;
        if (redirect_valid) begin
            next_pc = redirect_pc;
        end else if (advance) begin
            next_pc = pred_taken ? pred_target : seq_pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= `RESET_PC;
        end else begin
            fetch_pc <= {next_pc[`XLEN-1:2], 2'b00};
        end
    end

    // every source of the next pc is word aligned.
    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        next_pc[1:0] == 2'b00);

endmodule

//--- verilog/branch_predictor.sv
`timescale 1ns/100ps

`include "frontend_params.svh"

module branch_predictor (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [`XLEN-1:0] fetch_pc,
    input  logic [`XLEN-1:0] fetch_inst,
    output logic             pred_taken,
    output logic [`XLEN-1:0] pred_target,
    input  logic             upd_valid,
    input  logic [`XLEN-1:0] upd_pc,
    input  logic             upd_taken,
    input  logic [`XLEN-1:0] upd_target
);
    import predict_pkg::*;

    ctr2_t                 ctr_tbl [`BHT_ENTRIES];
    logic [`BHT_ENTRIES-1:0] btb_valid;
    logic [BTB_TAG_W-1:0]  btb_tag_mem [`BHT_ENTRIES];
    logic [`XLEN-1:0]      btb_target_mem [`BHT_ENTRIES];

    logic [`BHT_IDX_W-1:0] rd_idx;
    logic [`BHT_IDX_W-1:0] upd_idx;
    op_class_e             op_class;
    btb_entry_t            btb_rd;
    ctr2_t                 ctr_rd;
    ctr2_t                 ctr_upd;
    logic                  btb_hit;

    assign rd_idx  = bht_index(fetch_pc);
    assign upd_idx = bht_index(upd_pc);

    // pre-decode of the returned word.
    always_comb begin
        case (fetch_inst[6:0])
            OPC_BRANCH, OPC_JAL: op_class = op_class_e'(fetch_inst[6:0]);
            default:             op_class = OPC_OTHER;
        endcase
    end

    assign btb_rd = '{valid:  btb_valid[rd_idx],
                      tag:    btb_tag_mem[rd_idx],
                      target: btb_target_mem[rd_idx]};
    assign ctr_rd = ctr_tbl[rd_idx];

    assign btb_hit     = btb_rd.valid && (btb_rd.tag == btb_tag(fetch_pc));
    assign pred_taken  = btb_hit && ((op_class == OPC_JAL) ||
                         ((op_class == OPC_BRANCH) && (ctr_rd >= CTR_WEAK_T)));
    assign pred_target = btb_rd.target;

    // saturating step of the trained counter.
    always_comb begin
        ctr_upd = ctr_tbl[upd_idx];
        if (upd_taken && (ctr_upd != CTR_STRONG_T)) begin
            ctr_upd = ctr_upd + ctr2_t'(1);
        end else if (!upd_taken && (ctr_upd != CTR_STRONG_NT)) begin
            ctr_upd = ctr_upd - ctr2_t'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                ctr_tbl[i] <= CTR_WEAK_NT;
            end
            btb_valid <= '0;
        end else if (upd_valid) begin
            ctr_tbl[upd_idx] <= ctr_upd;
            if (upd_taken) begin
                btb_valid[upd_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid && upd_taken) begin
            btb_tag_mem[upd_idx]    <= btb_tag(upd_pc);
            btb_target_mem[upd_idx] <= upd_target;
        end
    end

endmodule

//--- verilog/inst_buffer.sv
`timescale 1ns/100ps

`include "frontend_params.svh"

module inst_buffer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   push,
    input  fetch_pkg::ibuf_entry_t push_entry,
    output logic                   space,
    output logic                   full,
    output logic                   dec_valid,
    output logic [`XLEN-1:0]       dec_pc,
    output logic [`XLEN-1:0]       dec_inst,
    output logic                   dec_pred_taken,
    output logic [`XLEN-1:0]       dec_pred_target,
    input  logic                   dec_ready
);
    import fetch_pkg::*;

    ibuf_entry_t             mem [`IBUF_DEPTH];
    logic [`IBUF_PTR_W-1:0]  wr_ptr;
    logic [`IBUF_PTR_W-1:0]  rd_ptr;
    logic [`IBUF_PTR_W:0]    count;
    logic [`IBUF_PTR_W+1:0]  held;
    logic                    pop;
    ibuf_entry_t             head;

    assign pop = dec_valid && dec_ready;

    // a word pushed this cycle already holds a slot.
    assign held  = {1'b0, count} + (`IBUF_PTR_W+2)'(push);
    assign space = held < (`IBUF_PTR_W+2)'(`IBUF_DEPTH);
    assign full  = count == (`IBUF_PTR_W+1)'(`IBUF_DEPTH);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    assign head = mem[rd_ptr];

    assign dec_valid       = count != '0;
    assign dec_pc          = head.pc;
    assign dec_inst        = head.inst;
    assign dec_pred_taken  = head.pred_taken;
    assign dec_pred_target = head.pred_target;

    // fetch control must hold off before the last slot is taken.
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> !full);

    // equal pointers below full mean the queue is empty.
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> (rd_ptr != wr_ptr) || full);

endmodule

//--- verilog/frontend_top.sv
`timescale 1ns/100ps

`include "frontend_params.svh"

module frontend_top (
    input  logic             clk,
    input  logic             arst_n,

    // wishbone read master toward instruction memory.
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic [`XLEN-1:0] wb_adr,
    input  logic [`XLEN-1:0] wb_dat_i,
    input  logic             wb_ack,

    // decoder side.
    output logic             dec_valid,
    input  logic             dec_ready,
    output logic [`XLEN-1:0] dec_pc,
    output logic [`XLEN-1:0] dec_inst,
    output logic             dec_pred_taken,
    output logic [`XLEN-1:0] dec_pred_target,

    // backend side.
    input  logic             redirect_valid,
    input  logic [`XLEN-1:0] redirect_pc,
    input  logic             upd_valid,
    input  logic [`XLEN-1:0] upd_pc,
    input  logic             upd_taken,
    input  logic [`XLEN-1:0] upd_target,
    output logic             buffer_full
);
    import fetch_pkg::*;

    // reads only, so the bus write enable stays low and is not brought out.
    logic [`XLEN-1:0] fetch_pc;
    logic [`XLEN-1:0] fetch_inst;
    logic             advance;
    logic             pred_taken;
    logic [`XLEN-1:0] pred_target;
    logic             push;
    ibuf_entry_t      push_entry;
    logic             ibuf_space;

    fetch_ctrl u_fetch_ctrl (
        .clk,
        .arst_n,
        .fetch_pc,
        .advance,
        .redirect_valid,
        .wb_cyc,
        .wb_stb,
        .wb_adr,
        .wb_dat_i,
        .wb_ack,
        .pred_taken,
        .pred_target,
        .fetch_inst,
        .push,
        .push_entry,
        .ibuf_space
    );

    pc_gen u_pc_gen (
        .clk,
        .arst_n,
        .advance,
        .pred_taken,
        .pred_target,
        .redirect_valid,
        .redirect_pc,
        .fetch_pc
    );

    branch_predictor u_branch_predictor (
        .clk,
        .arst_n,
        .fetch_pc,
        .fetch_inst,
        .pred_taken,
        .pred_target,
        .upd_valid,
        .upd_pc,
        .upd_taken,
        .upd_target
    );

    inst_buffer u_inst_buffer (
        .clk,
        .arst_n,
        .flush(redirect_valid),
        .push,
        .push_entry,
        .space(ibuf_space),
        .full(buffer_full),
        .dec_valid,
        .dec_pc,
        .dec_inst,
        .dec_pred_taken,
        .dec_pred_target,
        .dec_ready
    );

endmodule

//--- tests/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk,
    output logic arst_n
);

    // 4 ns period.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- tests/tb_frontend.sv
`timescale 1ns/100ps

`include "frontend_params.svh"

module tb_frontend;
    import predict_pkg::*;

    localparam logic [`XLEN-1:0] BR_PC      = 32'h0000_0400;
    localparam logic [`XLEN-1:0] BR_TARGET  = 32'h0000_0800;
    localparam logic [`XLEN-1:0] BR_WORD    = 32'h0020_8463;
    localparam logic [`XLEN-1:0] JAL_PC     = 32'h0000_0640;
    localparam logic [`XLEN-1:0] JAL_TARGET = 32'h0000_0900;
    localparam logic [`XLEN-1:0] JAL_WORD   = 32'h0080_006f;
    localparam int CYCLES_PER_ENTRY = 40;

    logic             clk;
    logic             arst_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic [`XLEN-1:0] wb_adr;
    logic [`XLEN-1:0] wb_dat_i = '0;
    logic             wb_ack = 1'b0;
    logic             dec_valid;
    logic             dec_ready = 1'b0;
    logic [`XLEN-1:0] dec_pc;
    logic [`XLEN-1:0] dec_inst;
    logic             dec_pred_taken;
    logic [`XLEN-1:0] dec_pred_target;
    logic             redirect_valid = 1'b0;
    logic [`XLEN-1:0] redirect_pc = '0;
    logic             upd_valid = 1'b0;
    logic [`XLEN-1:0] upd_pc = '0;
    logic             upd_taken = 1'b0;
    logic [`XLEN-1:0] upd_target = '0;
    logic             buffer_full;

    integer           seed = 80451;
    int               wait_left = -1;
    logic [1:0]       ready_mode = 2'd0;
    int               delivered = 0;
    int               taken_seen = 0;
    logic [`XLEN-1:0] exp_pc = `RESET_PC;

    // expected predictor state.
    ctr2_t                   ref_ctr [`BHT_ENTRIES] = '{default: 2'd1};
    logic                    ref_valid [`BHT_ENTRIES] = '{default: 1'b0};
    logic [`XLEN-1:`BHT_IDX_W+2] ref_tag [`BHT_ENTRIES];
    logic [`XLEN-1:0]        ref_target [`BHT_ENTRIES];

    tb_clkgen u_clkgen (
        .clk,
        .arst_n
    );

    frontend_top frontend_top_i (
        .clk,
        .arst_n,
        .wb_cyc,
        .wb_stb,
        .wb_adr,
        .wb_dat_i,
        .wb_ack,
        .dec_valid,
        .dec_ready,
        .dec_pc,
        .dec_inst,
        .dec_pred_taken,
        .dec_pred_target,
        .redirect_valid,
        .redirect_pc,
        .upd_valid,
        .upd_pc,
        .upd_taken,
        .upd_target,
        .buffer_full
    );

    task automatic check_eq(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s at %0t ns", what, $time);
        $display("*** TEST FAILED ***");
        $fatal(1, "wait ran out");
    endtask

    // filler words are plain ALU ops, never a branch or a jump.
    function automatic logic [`XLEN-1:0] mem_word(input logic [`XLEN-1:0] adr);
        logic [`XLEN-1:0] w;
        if (adr == BR_PC) begin
            return BR_WORD;
        end
        if (adr == JAL_PC) begin
            return JAL_WORD;
        end
        w = (adr * 32'h9e37_79b1) ^ {adr[15:0], adr[31:16]};
        return {w[`XLEN-1:7], 7'b0010011};
    endfunction

    // prediction for the word at pc, and the pc that should follow it.
    function automatic logic [`XLEN-1:0] next_expected(input logic [`XLEN-1:0] pc,
                                                       output logic taken,
                                                       output logic [`XLEN-1:0] target);
        logic [`BHT_IDX_W-1:0] idx;
        logic                  hit;
        logic [`XLEN-1:0]      word;
        idx    = pc[`BHT_IDX_W+1:2];
        word   = mem_word(pc);
        hit    = ref_valid[idx] && (ref_tag[idx] == pc[`XLEN-1:`BHT_IDX_W+2]);
        target = ref_target[idx];
        case (word[6:0])
            OPC_JAL:    taken = hit;
            OPC_BRANCH: taken = hit && (ref_ctr[idx] >= 2'd2);
            default:    taken = 1'b0;
        endcase
        return taken ? target : pc + 32'd4;
    endfunction

    function automatic void train_model(input logic [`XLEN-1:0] pc, input logic taken,
                                        input logic [`XLEN-1:0] target);
        logic [`BHT_IDX_W-1:0] idx;
        idx = pc[`BHT_IDX_W+1:2];
        if (taken && (ref_ctr[idx] != 2'd3)) begin
            ref_ctr[idx] = ref_ctr[idx] + 2'd1;
        end else if (!taken && (ref_ctr[idx] != 2'd0)) begin
            ref_ctr[idx] = ref_ctr[idx] - 2'd1;
        end
        if (taken) begin
            ref_valid[idx]  = 1'b1;
            ref_tag[idx]    = pc[`XLEN-1:`BHT_IDX_W+2];
            ref_target[idx] = target;
        end
    endfunction

    // instruction memory slave and decoder ready.
    always @(posedge clk) begin
        case (ready_mode)
            2'd0:    dec_ready <= 1'b0;
            2'd1:    dec_ready <= ($random(seed) & 1) != 0;
            default: dec_ready <= 1'b1;
        endcase
        wb_ack <= 1'b0;
        if (arst_n && wb_stb && !wb_ack) begin
            if (wait_left < 0) begin
                wait_left <= $unsigned($random(seed)) % 4;
            end else if (wait_left == 0) begin
                wb_ack    <= 1'b1;
                wb_dat_i  <= mem_word(wb_adr);
                wait_left <= -1;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        logic             exp_taken;
        logic [`XLEN-1:0] exp_target;
        logic [`XLEN-1:0] exp_next;
        if (arst_n) begin
            check_eq(32'(wb_stb && buffer_full), 32'd0, "wb_stb while buffer_full");
            if (dec_valid && dec_ready) begin
                exp_next = next_expected(exp_pc, exp_taken, exp_target);
                check_eq(dec_pc, exp_pc, "dec_pc");
                check_eq(dec_inst, mem_word(exp_pc), "dec_inst");
                check_eq(32'(dec_pred_taken), 32'(exp_taken), "dec_pred_taken");
                if (exp_taken) begin
                    check_eq(dec_pred_target, exp_target, "dec_pred_target");
                    taken_seen <= taken_seen + 1;
                end
                exp_pc    <= exp_next;
                delivered <= delivered + 1;
            end
            // the old path ends here and the new one starts at redirect_pc.
            if (redirect_valid) begin
                exp_pc <= redirect_pc;
            end
            if (upd_valid) begin
                train_model(upd_pc, upd_taken, upd_target);
            end
        end
    end

    task automatic sync_to_reset();
        int cycles;
        cycles = 0;
        while (!arst_n && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!arst_n) begin
            report_timeout("reset release");
        end
    endtask

    task automatic collect_entries(input int n, input string what);
        int target;
        int cycles;
        target = delivered + n;
        cycles = 0;
        while (delivered < target && cycles < n * CYCLES_PER_ENTRY) begin
            @(posedge clk);
            cycles++;
        end
        if (delivered < target) begin
            report_timeout(what);
        end
    endtask

    task automatic hunt_for_stb();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!(wb_stb && !wb_ack) && cycles < CYCLES_PER_ENTRY) begin
            @(posedge clk);
            cycles++;
        end
        if (!(wb_stb && !wb_ack)) begin
            report_timeout("a bus request to overtake");
        end
    endtask

    task automatic fill_until_full();
        int cycles;
        cycles = 0;
        while (!buffer_full && cycles < 8 * CYCLES_PER_ENTRY) begin
            @(posedge clk);
            cycles++;
        end
        if (!buffer_full) begin
            report_timeout("buffer_full with the decoder stalled");
        end
    endtask

    task automatic send_update(input logic [`XLEN-1:0] pc, input logic taken,
                               input logic [`XLEN-1:0] target);
        upd_valid  <= 1'b1;
        upd_pc     <= pc;
        upd_taken  <= taken;
        upd_target <= target;
        @(posedge clk);
        upd_valid <= 1'b0;
    endtask

    task automatic redirect_to(input logic [`XLEN-1:0] pc);
        redirect_valid <= 1'b1;
        redirect_pc    <= pc;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    initial begin
        sync_to_reset();
        check_eq(32'(wb_cyc), 32'd0, "wb_cyc after reset");
        check_eq(32'(wb_stb), 32'd0, "wb_stb after reset");
        check_eq(32'(dec_valid), 32'd0, "dec_valid after reset");
        check_eq(32'(buffer_full), 32'd0, "buffer_full after reset");
        ready_mode <= 2'd2;
        collect_entries(8, "sequential fetch after reset");

        ready_mode <= 2'd1;
        collect_entries(16, "deliveries with random decoder ready");
        ready_mode <= 2'd0;
        fill_until_full();
        ready_mode <= 2'd1;
        collect_entries(16, "draining a full buffer");

        hunt_for_stb();
        redirect_to(32'h0000_0200);
        collect_entries(10, "fetch after a redirect");

        // taken branch at BR_PC, reached from two words before it.
        send_update(BR_PC, 1'b1, BR_TARGET);
        redirect_to(BR_PC - 32'd8);
        collect_entries(6, "fetch through the trained branch");
        check_eq(taken_seen, 32'd1, "taken predictions after branch training");

        // two not-taken updates pull the counter down to strongly not taken.
        send_update(BR_PC, 1'b0, BR_TARGET);
        send_update(BR_PC, 1'b0, BR_TARGET);
        redirect_to(BR_PC - 32'd4);
        collect_entries(6, "fetch through the decayed branch");
        check_eq(taken_seen, 32'd1, "taken predictions after counter decay");

        // the jump shares the decayed slot, so its counter stays weakly not taken.
        send_update(JAL_PC, 1'b1, JAL_TARGET);
        redirect_to(JAL_PC - 32'd4);
        collect_entries(6, "fetch through the trained jump");
        check_eq(taken_seen, 32'd2, "taken predictions after jump training");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- frontend.f
+incdir+include
verilog/fetch_pkg.sv
verilog/predict_pkg.sv
verilog/fetch_ctrl.sv
verilog/pc_gen.sv
verilog/branch_predictor.sv
verilog/inst_buffer.sv
verilog/frontend_top.sv
tests/tb_clkgen.sv
tests/tb_frontend.sv

//--- Makefile
TOP := tb_frontend

.PHONY: help test clean

help:
	@echo "make targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -j 0 --timescale 1ns/100ps \
		--top-module $(TOP) -f frontend.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
